// ==== source/arp_pkg.sv ====
package arp_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;

    typedef struct packed {
        mac_addr_t  mac;
        ipv4_addr_t ip;
    } arp_peer_t;

    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
    localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
    localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ARP_OP_REQUEST = 16'h0001;
    localparam logic [15:0] ARP_OP_REPLY   = 16'h0002;

    localparam byte_t     PREAMBLE_BYTE = 8'h55;
    localparam byte_t     SFD_BYTE      = 8'hd5;
    localparam mac_addr_t BROADCAST_MAC = 48'hffff_ffff_ffff;

    localparam int PAD_BYTES  = 18;  // 42 + 18 = 60 byte minimum frame
    localparam int IFG_CYCLES = 12;

    localparam logic [31:0] CRC32_POLY = 32'hedb8_8320;  // 04c11db7 reflected

    typedef enum logic [2:0] {
        rx_idle,
        rx_preamble,
        rx_eth_head,
        rx_arp_head,
        rx_arp_data
    } rx_state_t;

    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_sfd,
        tx_header,
        tx_pad,
        tx_fcs,
        tx_gap
    } tx_state_t;

endpackage

// ==== source/eth_crc32.sv ====
`timescale 1ns/1ps

module eth_crc32 (
    input  logic           rstn,
    input  logic           gmii_rx_clk,
    input  logic           crc_init,
    input  logic           crc_en,
    input  arp_pkg::byte_t crc_data,
    output logic [31:0]    fcs
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // lsb-first, one bit per step, eight steps per byte
    always_comb begin
        crc_next = crc_q ^ {24'd0, crc_data};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ arp_pkg::CRC32_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            crc_q <= '1;
        end else if (crc_init) begin
            crc_q <= '1;  // preset
        end else if (crc_en) begin
            crc_q <= crc_next;
        end
    end

    // reflected register, so byte 0 of the fcs sits in bits 7:0
    assign fcs = ~crc_q;

endmodule

// ==== source/arp_rx.sv ====
`timescale 1ns/1ps

module arp_rx (
    input  logic                rstn,
    input  logic                gmii_rx_clk,
    input  logic                gmii_rx_dv,
    input  arp_pkg::byte_t      gmii_rxd,
    input  arp_pkg::ipv4_addr_t board_ip,
    output arp_pkg::arp_peer_t  peer,
    output logic                peer_valid
);

    arp_pkg::rx_state_t  state;
    logic [4:0]          cnt;       // byte index within the current section
    logic                wait_low;  // frame over, hold off until dv falls

    arp_pkg::mac_addr_t  dst_mac;
    arp_pkg::byte_t      type_hi;
    logic [15:0]         htype;
    logic [15:0]         ptype;
    arp_pkg::byte_t      oper_hi;
    arp_pkg::mac_addr_t  snd_mac;
    arp_pkg::ipv4_addr_t snd_ip;
    arp_pkg::ipv4_addr_t tgt_ip;

    logic eth_ok;
    logic arp_ok;
    logic accept;

    // field checks are made while the last byte of the group is on gmii_rxd
    assign eth_ok = (dst_mac == arp_pkg::BROADCAST_MAC) &&
                    ({type_hi, gmii_rxd} == arp_pkg::ETH_TYPE_ARP);

    assign arp_ok = (htype == arp_pkg::ARP_HTYPE_ETH) &&
                    (ptype == arp_pkg::ARP_PTYPE_IPV4) &&
                    ({oper_hi, gmii_rxd} == arp_pkg::ARP_OP_REQUEST);

    assign accept = (state == arp_pkg::rx_arp_data) && gmii_rx_dv &&
                    (cnt == 5'd20) && (tgt_ip == board_ip);  // byte after target ip

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state      <= arp_pkg::rx_idle;
            cnt        <= '0;
            wait_low   <= 1'b0;
            peer_valid <= 1'b0;
        end else begin
            peer_valid <= 1'b0;
            if ((state != arp_pkg::rx_idle) && !gmii_rx_dv) begin
                state    <= arp_pkg::rx_idle;  // frame cut short
                wait_low <= 1'b0;
            end else begin
                case (state)
                    arp_pkg::rx_idle: begin
                        cnt <= 5'd1;  // first preamble byte taken here
                        if (!gmii_rx_dv) begin
                            wait_low <= 1'b0;
                        end else if (!wait_low) begin
                            if (gmii_rxd == arp_pkg::PREAMBLE_BYTE) begin
                                state <= arp_pkg::rx_preamble;
                            end else begin
                                wait_low <= 1'b1;
                            end
                        end
                    end
                    arp_pkg::rx_preamble: begin
                        cnt <= cnt + 5'd1;
                        if (cnt == 5'd7) begin
                            cnt <= '0;
                            if (gmii_rxd == arp_pkg::SFD_BYTE) begin
                                state <= arp_pkg::rx_eth_head;
                            end else begin
                                state    <= arp_pkg::rx_idle;
                                wait_low <= 1'b1;
                            end
                        end else if (gmii_rxd != arp_pkg::PREAMBLE_BYTE) begin
                            state    <= arp_pkg::rx_idle;
                            wait_low <= 1'b1;
                        end
                    end
                    arp_pkg::rx_eth_head: begin
                        cnt <= cnt + 5'd1;
                        if (cnt == 5'd13) begin
                            cnt <= '0;
                            if (eth_ok) begin
                                state <= arp_pkg::rx_arp_head;
                            end else begin
                                state    <= arp_pkg::rx_idle;
                                wait_low <= 1'b1;
                            end
                        end
                    end
                    arp_pkg::rx_arp_head: begin
                        cnt <= cnt + 5'd1;
                        if (cnt == 5'd7) begin
                            cnt <= '0;
                            if (arp_ok) begin
                                state <= arp_pkg::rx_arp_data;
                            end else begin
                                state    <= arp_pkg::rx_idle;
                                wait_low <= 1'b1;
                            end
                        end
                    end
                    arp_pkg::rx_arp_data: begin
                        cnt <= cnt + 5'd1;
                        if (cnt == 5'd20) begin
                            cnt        <= '0;
                            state      <= arp_pkg::rx_idle;
                            wait_low   <= 1'b1;  // rest of frame and fcs ignored
                            peer_valid <= accept;
                        end
                    end
                    default: begin
                        state <= arp_pkg::rx_idle;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (gmii_rx_dv) begin
            case (state)
                arp_pkg::rx_eth_head: begin
                    if (cnt < 5'd6) begin
                        dst_mac <= {dst_mac[39:0], gmii_rxd};
                    end
                    if (cnt == 5'd12) begin
                        type_hi <= gmii_rxd;
                    end
                end
                arp_pkg::rx_arp_head: begin
                    if (cnt < 5'd2) begin
                        htype <= {htype[7:0], gmii_rxd};
                    end else if (cnt < 5'd4) begin
                        ptype <= {ptype[7:0], gmii_rxd};
                    end else if (cnt == 5'd6) begin
                        oper_hi <= gmii_rxd;  // hlen and plen skipped
                    end
                end
                arp_pkg::rx_arp_data: begin
                    if (cnt < 5'd6) begin
                        snd_mac <= {snd_mac[39:0], gmii_rxd};
                    end else if (cnt < 5'd10) begin
                        snd_ip <= {snd_ip[23:0], gmii_rxd};
                    end else if ((cnt >= 5'd16) && (cnt < 5'd20)) begin
                        tgt_ip <= {tgt_ip[23:0], gmii_rxd};
                    end
                end
                default: begin
                end
            endcase
        end
        if (accept) begin
            peer.mac <= snd_mac;
            peer.ip  <= snd_ip;
        end
    end

    a_pv_single: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        peer_valid |=> !peer_valid)
        else $error("peer_valid held for more than one cycle");

    a_pv_from_data: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        peer_valid |-> ($past(state) == arp_pkg::rx_arp_data))
        else $error("peer_valid without a completed arp payload");

endmodule

// ==== source/arp_tx.sv ====
`timescale 1ns/1ps

module arp_tx (
    input  logic                rstn,
    input  logic                gmii_rx_clk,
    input  arp_pkg::mac_addr_t  board_mac,
    input  arp_pkg::ipv4_addr_t board_ip,
    input  arp_pkg::arp_peer_t  peer,
    input  logic                peer_valid,
    input  logic [31:0]         fcs,
    output logic                crc_init,
    output logic                crc_en,
    output arp_pkg::byte_t      crc_data,
    output logic                gmii_tx_en,
    output arp_pkg::byte_t      gmii_txd
);

    arp_pkg::tx_state_t state;
    logic [5:0]         cnt;
    arp_pkg::arp_peer_t peer_q;
    logic [335:0]       hdr;  // 14 eth + 28 arp bytes, first byte on top
    arp_pkg::byte_t     hdr_byte;

    assign hdr = {
        peer_q.mac,
        board_mac,
        arp_pkg::ETH_TYPE_ARP,
        arp_pkg::ARP_HTYPE_ETH,
        arp_pkg::ARP_PTYPE_IPV4,
        8'd6,                   // hlen
        8'd4,                   // plen
        arp_pkg::ARP_OP_REPLY,
        board_mac,
        board_ip,
        peer_q.mac,
        peer_q.ip
    };

    assign hdr_byte = hdr[8 * (41 - cnt) +: 8];

    // crc sees each byte on the same edge that puts it on gmii_txd,
    // so fcs is settled by the first fcs cycle
    assign crc_init = (state == arp_pkg::tx_sfd);
    assign crc_en   = (state == arp_pkg::tx_header) || (state == arp_pkg::tx_pad);
    assign crc_data = (state == arp_pkg::tx_header) ? hdr_byte : '0;

    always_ff @(posedge gmii_rx_clk) begin
        if ((state == arp_pkg::tx_idle) && peer_valid) begin
            peer_q <= peer;
        end
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state      <= arp_pkg::tx_idle;
            cnt        <= '0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
        end else begin
            case (state)
                arp_pkg::tx_idle: begin
                    if (peer_valid) begin
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= arp_pkg::PREAMBLE_BYTE;
                        cnt        <= 6'd1;
                        state      <= arp_pkg::tx_preamble;
                    end
                end
                arp_pkg::tx_preamble: begin
                    gmii_txd <= arp_pkg::PREAMBLE_BYTE;
                    cnt      <= cnt + 6'd1;
                    if (cnt == 6'd6) begin
                        state <= arp_pkg::tx_sfd;
                    end
                end
                arp_pkg::tx_sfd: begin
                    gmii_txd <= arp_pkg::SFD_BYTE;
                    cnt      <= '0;
                    state    <= arp_pkg::tx_header;
                end
                arp_pkg::tx_header: begin
                    gmii_txd <= hdr_byte;
                    cnt      <= cnt + 6'd1;
                    if (cnt == 6'd41) begin
                        cnt   <= '0;
                        state <= arp_pkg::tx_pad;
                    end
                end
                arp_pkg::tx_pad: begin
                    gmii_txd <= '0;
                    cnt      <= cnt + 6'd1;
                    if (cnt == 6'(arp_pkg::PAD_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= arp_pkg::tx_fcs;
                    end
                end
                arp_pkg::tx_fcs: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'd4) begin
                        gmii_tx_en <= 1'b0;  // first idle cycle of the gap
                        gmii_txd   <= '0;
                        cnt        <= '0;
                        state      <= arp_pkg::tx_gap;
                    end else begin
                        gmii_txd <= fcs[8 * cnt[1:0] +: 8];  // low byte first
                    end
                end
                arp_pkg::tx_gap: begin
                    cnt <= cnt + 6'd1;
                    // fcs exit and idle sampling make up the other two
                    if (cnt == 6'(arp_pkg::IFG_CYCLES - 2)) begin
                        cnt   <= '0;
                        state <= arp_pkg::tx_idle;
                    end
                end
                default: begin
                    state <= arp_pkg::tx_idle;
                end
            endcase
        end
    end

    a_en_quiet: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        (state inside {arp_pkg::tx_idle, arp_pkg::tx_gap}) |-> !gmii_tx_en)
        else $error("gmii_tx_en high outside a frame");

    a_crc_in_frame: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        crc_en |-> gmii_tx_en)
        else $error("crc advanced while no frame is on the wire");

endmodule

// ==== source/arp_responder.sv ====
`timescale 1ns/1ps

module arp_responder (
    input  logic                rstn,
    input  logic                gmii_rx_clk,
    input  logic                gmii_rx_dv,
    input  arp_pkg::byte_t      gmii_rxd,
    input  arp_pkg::mac_addr_t  board_mac,
    input  arp_pkg::ipv4_addr_t board_ip,
    output logic                gmii_tx_en,
    output arp_pkg::byte_t      gmii_txd,
    output arp_pkg::arp_peer_t  peer,
    output logic                peer_valid
);

    logic           crc_init;
    logic           crc_en;
    arp_pkg::byte_t crc_data;
    logic [31:0]    fcs;

    arp_rx arp_rx_i (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rxd    (gmii_rxd),
        .board_ip    (board_ip),
        .peer        (peer),
        .peer_valid  (peer_valid)
    );

    arp_tx arp_tx_i (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .board_mac   (board_mac),
        .board_ip    (board_ip),
        .peer        (peer),
        .peer_valid  (peer_valid),
        .fcs         (fcs),
        .crc_init    (crc_init),
        .crc_en      (crc_en),
        .crc_data    (crc_data),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd)
    );

    eth_crc32 eth_crc32_i (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .crc_init    (crc_init),
        .crc_en      (crc_en),
        .crc_data    (crc_data),
        .fcs         (fcs)
    );

endmodule

// ==== test/arp_tb_tasks.svh ====
`ifndef ARP_TB_TASKS_SVH
`define ARP_TB_TASKS_SVH

// galois form of x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

task automatic draw_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v    = {v[62:0], lfsr[0]};  // one step per bit
    end
endtask

// forward register on 04c11db7, data bits fed lsb first, result bit reversed
function automatic logic [31:0] crc32_ref(input arp_pkg::byte_t data[60]);
    logic [31:0] crc;
    logic [31:0] rev;
    logic        fb;
    crc = '1;
    for (int i = 0; i < 60; i++) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[31] ^ data[i][b];
            crc = {crc[30:0], 1'b0};
            if (fb) begin
                crc = crc ^ 32'h04c1_1db7;
            end
        end
    end
    for (int b = 0; b < 32; b++) begin
        rev[b] = crc[31 - b];
    end
    return ~rev;  // byte 0 of the fcs in bits 7:0
endfunction

task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        errors++;
        $display("ERR %s: got %0h, expected %0h", name, got, exp);
    end
endtask

task automatic idle(input int n);
    repeat (n) @(posedge gmii_rx_clk);
endtask

task automatic send_frame(input arp_pkg::arp_peer_t req, input arp_pkg::ipv4_addr_t tgt_ip,
                          input string kind);
    arp_pkg::byte_t frm[72];
    arp_pkg::byte_t body[60];
    logic [335:0]   hdr;
    logic [31:0]    fcs;
    hdr = {arp_pkg::BROADCAST_MAC, req.mac, arp_pkg::ETH_TYPE_ARP,
           arp_pkg::ARP_HTYPE_ETH, arp_pkg::ARP_PTYPE_IPV4, 8'd6, 8'd4,
           arp_pkg::ARP_OP_REQUEST, req.mac, req.ip, 48'd0, tgt_ip};
    for (int i = 0; i < 42; i++) begin
        body[i] = hdr[8 * (41 - i) +: 8];
    end
    for (int i = 42; i < 60; i++) begin
        body[i] = 8'h00;
    end
    if (kind == "unicast") begin
        body[0] = 8'h02;  // 02:ff:ff:ff:ff:ff
    end else if (kind == "ethertype") begin
        body[13] = 8'h00;  // 0800
    end else if (kind == "htype") begin
        body[15] = 8'h06;
    end else if (kind == "ptype") begin
        body[17] = 8'hdd;
    end else if (kind == "oper") begin
        body[21] = 8'h02;
    end
    fcs = crc32_ref(body);
    for (int i = 0; i < 7; i++) begin
        frm[i] = arp_pkg::PREAMBLE_BYTE;
    end
    frm[7] = arp_pkg::SFD_BYTE;
    for (int i = 0; i < 60; i++) begin
        frm[8 + i] = body[i];
    end
    for (int i = 0; i < 4; i++) begin
        frm[68 + i] = fcs[8 * i +: 8];
    end
    if (kind == "preamble") begin
        frm[3] = 8'h5d;
    end else if (kind == "sfd") begin
        frm[7] = arp_pkg::PREAMBLE_BYTE;  // eighth preamble byte instead of sfd
    end
    for (int i = 0; i < 72; i++) begin
        @(posedge gmii_rx_clk);
        gmii_rx_dv <= !((kind == "dv_drop") && (i == 40));  // dv drop lands in the target mac
        gmii_rxd   <= frm[i];
        if (i == 49) begin
            arp_end_cyc = cycles + 2;  // count after the edge that samples it
        end
    end
    @(posedge gmii_rx_clk);
    gmii_rx_dv <= 1'b0;
    gmii_rxd   <= '0;
endtask

task automatic expect_reply(input arp_pkg::arp_peer_t req);
    arp_pkg::byte_t exp_b[72];
    arp_pkg::byte_t body[60];
    logic [335:0]   hdr;
    logic [31:0]    fcs;
    int             waited;
    hdr = {req.mac, board_mac, arp_pkg::ETH_TYPE_ARP,
           arp_pkg::ARP_HTYPE_ETH, arp_pkg::ARP_PTYPE_IPV4, 8'd6, 8'd4,
           arp_pkg::ARP_OP_REPLY, board_mac, board_ip, req.mac, req.ip};
    for (int i = 0; i < 42; i++) begin
        body[i] = hdr[8 * (41 - i) +: 8];
    end
    for (int i = 42; i < 60; i++) begin
        body[i] = 8'h00;
    end
    fcs = crc32_ref(body);
    for (int i = 0; i < 7; i++) begin
        exp_b[i] = arp_pkg::PREAMBLE_BYTE;
    end
    exp_b[7] = arp_pkg::SFD_BYTE;
    for (int i = 0; i < 60; i++) begin
        exp_b[8 + i] = body[i];
    end
    for (int i = 0; i < 4; i++) begin
        exp_b[68 + i] = fcs[8 * i +: 8];
    end
    waited = 0;
    @(negedge gmii_rx_clk);
    while ((gmii_tx_en !== 1'b1) && (waited < 200)) begin
        @(negedge gmii_rx_clk);
        waited++;
    end
    if (gmii_tx_en !== 1'b1) begin
        errors++;
        $display("no reply frame appeared within %0d cycles", waited);
        return;
    end
    check("gmii_tx_en rise cycle", cycles, arp_end_cyc + 2);
    for (int i = 0; i < 72; i++) begin
        if (i > 0) begin
            @(negedge gmii_rx_clk);
        end
        check("gmii_tx_en", gmii_tx_en, 1'b1);
        check($sformatf("gmii_txd[%0d]", i), gmii_txd, exp_b[i]);
    end
    @(negedge gmii_rx_clk);
    check("gmii_tx_en", gmii_tx_en, 1'b0);  // frame is exactly 72 bytes
endtask

task automatic expect_silence(input int n);
    logic rose;
    rose = 1'b0;
    repeat (n) begin
        @(negedge gmii_rx_clk);
        if (gmii_tx_en !== 1'b0) begin
            rose = 1'b1;
        end
    end
    if (rose) begin
        errors++;
        $display("gmii_tx_en went high although no reply was expected");
    end
endtask

`endif

// ==== test/arp_responder_tb.sv ====
`timescale 1ns/1ps

module arp_responder_tb;

    logic                gmii_rx_clk;
    logic                rstn;
    logic                gmii_rx_dv;
    arp_pkg::byte_t      gmii_rxd;
    arp_pkg::mac_addr_t  board_mac;
    arp_pkg::ipv4_addr_t board_ip;
    logic                gmii_tx_en;
    arp_pkg::byte_t      gmii_txd;
    arp_pkg::arp_peer_t  peer;
    logic                peer_valid;

    int unsigned         cycles;
    int unsigned         max_cycles;
    int unsigned         errors;
    int unsigned         pv_count;
    int unsigned         arp_end_cyc;
    arp_pkg::arp_peer_t  last_peer;
    logic [15:0]         lfsr;

    arp_responder arp_responder_i (
        .rstn        (rstn),
        .gmii_rx_clk (gmii_rx_clk),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rxd    (gmii_rxd),
        .board_mac   (board_mac),
        .board_ip    (board_ip),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .peer        (peer),
        .peer_valid  (peer_valid)
    );

    `include "arp_tb_tasks.svh"

    initial begin
        gmii_rx_clk = 1'b0;
        forever #10 gmii_rx_clk = ~gmii_rx_clk;
    end

    always @(posedge gmii_rx_clk) begin
        cycles <= cycles + 1;
    end

    always @(negedge gmii_rx_clk) begin
        if (peer_valid === 1'b1) begin
            pv_count  = pv_count + 1;
            last_peer = peer;
        end
    end

    initial begin
        // 23 frames, each with a reply or a silence window and the gap
        max_cycles = 23 * (72 + 80 + arp_pkg::IFG_CYCLES) * 3 / 2;
        wait (cycles >= max_cycles);
        $display("timeout: test sequence still running after %0d cycles", cycles);
        $display("Checks failed");
        $finish;
    end

    task automatic request_and_reply(input arp_pkg::arp_peer_t req);
        int unsigned pv_before;
        pv_before = pv_count;
        fork
            send_frame(req, board_ip, "none");
            expect_reply(req);
        join
        idle(arp_pkg::IFG_CYCLES);
        check("peer_valid count", pv_count - pv_before, 1);
        check("peer.mac", last_peer.mac, req.mac);
        check("peer.ip", last_peer.ip, req.ip);
    endtask

    task automatic request_and_silence(input arp_pkg::arp_peer_t req,
                                       input arp_pkg::ipv4_addr_t tgt_ip, input string kind);
        int unsigned pv_before;
        pv_before = pv_count;
        fork
            send_frame(req, tgt_ip, kind);
            expect_silence(72 + 80);
        join
        @(posedge gmii_rx_clk);
        check("peer_valid count", pv_count - pv_before, 0);
    endtask

    task automatic test_valid_request();
        arp_pkg::arp_peer_t req;
        req.mac = 48'h00_1b_21_3a_4c_5d;
        req.ip  = 32'hc0a8_0105;
        request_and_reply(req);
    endtask

    task automatic test_wrong_target();
        arp_pkg::arp_peer_t req;
        req.mac = 48'h00_1b_21_3a_4c_5e;
        req.ip  = 32'hc0a8_0106;
        request_and_silence(req, board_ip ^ 32'h0000_0001, "none");
    endtask

    task automatic test_bad_fields();
        arp_pkg::arp_peer_t req;
        req.mac = 48'h3c_97_0e_11_22_33;
        req.ip  = 32'hc0a8_0107;
        request_and_silence(req, board_ip, "unicast");
        request_and_silence(req, board_ip, "ethertype");
        request_and_silence(req, board_ip, "oper");
        request_and_silence(req, board_ip, "htype");
        request_and_silence(req, board_ip, "ptype");
        request_and_reply(req);  // receiver recovered
    endtask

    task automatic test_bad_framing();
        arp_pkg::arp_peer_t req;
        req.mac = 48'h3c_97_0e_44_55_66;
        req.ip  = 32'hc0a8_0108;
        request_and_silence(req, board_ip, "preamble");
        request_and_silence(req, board_ip, "sfd");
        request_and_silence(req, board_ip, "dv_drop");
        request_and_reply(req);
    endtask

    task automatic test_busy_drop();
        arp_pkg::arp_peer_t req_a;
        arp_pkg::arp_peer_t req_b;
        arp_pkg::arp_peer_t req_c;
        int unsigned        pv_before;
        req_a.mac = 48'h00_0a_35_00_00_01;
        req_a.ip  = 32'h0a00_0001;
        req_b.mac = 48'h00_0a_35_00_00_02;
        req_b.ip  = 32'h0a00_0002;
        req_c.mac = 48'h00_0a_35_00_00_03;
        req_c.ip  = 32'h0a00_0003;
        pv_before = pv_count;
        fork
            begin
                send_frame(req_a, board_ip, "none");
                send_frame(req_b, board_ip, "none");  // strobe lands in tx gap
            end
            expect_reply(req_a);
        join
        expect_silence(80);
        @(posedge gmii_rx_clk);
        check("peer_valid count", pv_count - pv_before, 2);
        check("peer.mac", last_peer.mac, req_b.mac);
        request_and_reply(req_c);
    endtask

    task automatic test_random_requests();
        arp_pkg::arp_peer_t req;
        logic [63:0]        v;
        repeat (8) begin
            draw_bits(48, v);
            req.mac = v[47:0];
            draw_bits(32, v);
            req.ip = v[31:0];
            request_and_reply(req);
        end
    endtask

    initial begin
        rstn        = 1'b0;
        gmii_rx_dv  = 1'b0;
        gmii_rxd    = '0;
        board_mac   = 48'h02_00_5e_10_20_30;
        board_ip    = 32'hc0a8_0164;  // 192.168.1.100
        lfsr        = 16'd37878;
        errors      = 0;
        pv_count    = 0;
        arp_end_cyc = 0;
        repeat (2) @(posedge gmii_rx_clk);
        rstn <= 1'b1;
        @(negedge gmii_rx_clk);
        check("gmii_tx_en", gmii_tx_en, 1'b0);
        check("gmii_txd", gmii_txd, 8'h00);
        check("peer_valid", peer_valid, 1'b0);
        idle(2);
        test_valid_request();
        test_wrong_target();
        test_bad_fields();
        test_bad_framing();
        test_busy_drop();
        test_random_requests();
        $display("arp_responder_tb: %0d errors, %0d peer_valid strobes", errors, pv_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+test
source/arp_pkg.sv
source/eth_crc32.sv
source/arp_rx.sv
source/arp_tx.sv
source/arp_responder.sv
test/arp_responder_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the simulation with verilator, run it, and look for the pass line
verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module arp_responder_tb \
    -o arp_responder_sim \
    && ./obj_dir/arp_responder_sim | tee /dev/stderr | grep -q "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
